/* Makefile */
VERILATOR ?= verilator
TOP       ?= memSubsystem_tb
FILELIST  ?= list.f
OBJDIR    ?= obj_dir
LOG       ?= sim.log
JOBS      ?= 0
VFLAGS    ?= --binary --assert -j $(JOBS)
PASS_MSG  ?= all tests passed
FAIL_MSG  ?= tests failed

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)

run: build
	./$(OBJDIR)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "Simulation FAILED"; exit 1; fi
	@grep -q "$(PASS_MSG)" $(LOG) || { echo "Simulation ended without passing"; exit 1; }

lint:
	$(VERILATOR) --lint-only -Wall --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJDIR) $(LOG)

/* list.f */
+incdir+rtl
rtl/memPkg.sv
rtl/memBus_if.sv
rtl/memHandler.sv
rtl/apbMaster.sv
rtl/dataMemory.sv
rtl/memSubsystem.sv
tests/memSubsystem_assert.sv
tests/memSubsystem_tb.sv

/* rtl/apbMaster.sv */
`include "mem_defs.svh"
`timescale 1ns/1ps
`default_nettype none

module apbMaster import memPkg::*; (
    input  logic                   clk,
    input  logic                   rstN,
    memBus_if.completer            bus,
    output logic                   PSEL,
    output logic                   PENABLE,
    output logic                   PWRITE,
    output logic [`ADDR_WIDTH-1:0] PADDR,
    output logic [`DATA_WIDTH-1:0] PWDATA,
    output logic [3:0]             PSTRB,
    input  logic [`DATA_WIDTH-1:0] PRDATA,
    input  logic                   PREADY,
    input  logic                   PSLVERR
);
    apbStateE state;
    apbStateE stateNext;
    logic     startReq;  // Request accepted in idle
    logic     accessEnd; // Slave finished the transfer

    assign startReq  = (state == apbIdle) && bus.req;
    assign accessEnd = (state == apbAccess) && PREADY;

    always_comb begin
        stateNext = state;
        case (state)
            apbIdle: begin
                if (bus.req) begin
                    stateNext = apbSetup;
                end
            end
            apbSetup: stateNext = apbAccess; // Setup lasts exactly one cycle
            apbAccess: begin
                if (PREADY) begin
                    stateNext = apbIdle; // Wait states keep us here
                end
            end
            default: stateNext = apbIdle;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rstN) begin
            state    <= apbIdle;
            bus.done <= 1'b0;
        end else begin
            state    <= stateNext;
            bus.done <= accessEnd; // Completion one cycle after PREADY
        end
    end

    // Request fields held on the APB outputs for the whole transfer
    always_ff @(posedge clk) begin
        if (startReq) begin
            PADDR  <= bus.addr;
            PWDATA <= bus.wdata;
            PSTRB  <= bus.strb;
            PWRITE <= (bus.dir == busWrite);
        end
    end

    // Response captured on the PREADY cycle
    always_ff @(posedge clk) begin
        if (accessEnd) begin
            bus.rdata <= PRDATA;
            bus.err   <= PSLVERR;
        end
    end

    assign PSEL    = (state != apbIdle);
    assign PENABLE = (state == apbAccess);

endmodule

`default_nettype wire

/* rtl/dataMemory.sv */
`include "mem_defs.svh"
`timescale 1ns/1ps
`default_nettype none

module dataMemory (
    input  logic                   clk,
    input  logic                   rstN,
    input  logic                   PSEL,
    input  logic                   PENABLE,
    input  logic                   PWRITE,
    input  logic [`ADDR_WIDTH-1:0] PADDR,
    input  logic [`DATA_WIDTH-1:0] PWDATA,
    input  logic [3:0]             PSTRB,
    output logic [`DATA_WIDTH-1:0] PRDATA,
    output logic                   PREADY,
    output logic                   PSLVERR
);
    localparam int IDX_W = $clog2(`MEM_WORDS);
    localparam int CNT_W = (`MEM_WAIT_STATES > 0) ? $clog2(`MEM_WAIT_STATES + 1) : 1;

    logic [`DATA_WIDTH-1:0] mem [`MEM_WORDS] = '{default: '0}; // Starts cleared
    logic [CNT_W-1:0]       waitCnt;  // Access cycles seen so far
    logic                   inAccess; // Access phase of a transfer
    logic                   inRange;  // Address inside the array
    logic [IDX_W-1:0]       wordIdx;

    assign inAccess = PSEL & PENABLE;
    assign inRange  = (PADDR[`ADDR_WIDTH-1:IDX_W+2] == '0);
    assign wordIdx  = PADDR[IDX_W+1:2]; // Drop the byte offset

    always_ff @(posedge clk) begin
        if (!rstN) begin
            waitCnt <= '0;
        end else if (inAccess && !PREADY) begin
            waitCnt <= waitCnt + 1'b1;
        end else begin
            waitCnt <= '0; // Rearm for the next transfer
        end
    end

    assign PREADY  = inAccess && (waitCnt == CNT_W'(`MEM_WAIT_STATES));
    assign PSLVERR = PREADY & ~inRange; // Error only on the completing cycle
    assign PRDATA  = (PREADY && !PWRITE && inRange) ? mem[wordIdx] : '0;

    // Only strobed lanes change
    always_ff @(posedge clk) begin
        if (PREADY && PWRITE && inRange) begin
            for (int b = 0; b < 4; b++) begin
                if (PSTRB[b]) begin
                    mem[wordIdx][8*b +: 8] <= PWDATA[8*b +: 8];
                end
            end
        end
    end

endmodule

`default_nettype wire

/* rtl/memBus_if.sv */
`include "mem_defs.svh"
`timescale 1ns/1ps
`default_nettype none

interface memBus_if import memPkg::*; (
    input logic clk
);
    logic                   req;   // One-cycle request pulse
    busDirE                 dir;   // Read or write
    logic [`ADDR_WIDTH-1:0] addr;  // Word-aligned byte address
    logic [`DATA_WIDTH-1:0] wdata; // Store data already in its lane
    logic [3:0]             strb;  // Byte enables, zero on reads
    logic [`DATA_WIDTH-1:0] rdata; // Raw word from the slave
    logic                   done;  // One-cycle completion pulse
    logic                   err;   // Slave error, qualified by done

    // Load/store handler side
    modport requester (
        input  clk,
        output req, dir, addr, wdata, strb,
        input  rdata, done, err
    );

    // Bus master side
    modport completer (
        input  clk,
        input  req, dir, addr, wdata, strb,
        output rdata, done, err
    );

endinterface

`default_nettype wire

/* rtl/memHandler.sv */
`include "mem_defs.svh"
`timescale 1ns/1ps
`default_nettype none

module memHandler import memPkg::*; (
    input  logic                   clk,
    input  logic                   rstN,
    input  memOpE                  memOp,
    input  logic                   memWrite,
    input  logic                   memRead,
    input  logic                   memSource,  // High stores FPU data
    input  logic [`ADDR_WIDTH-1:0] aluAddress,
    input  logic [`DATA_WIDTH-1:0] fpuData,
    input  logic [`DATA_WIDTH-1:0] regData,
    output logic [`DATA_WIDTH-1:0] dataToCpu,
    output logic                   freeze,
    output logic                   memError,
    memBus_if.requester            bus
);
    logic                   access;     // Any request from the control unit
    logic                   goodOp;     // Code legal for this direction
    logic                   misaligned; // Address does not fit the width
    logic                   pending;    // Access outstanding on the bus
    logic [3:0]             laneMask;   // Strobes before the lane shift
    logic [4:0]             laneShift;  // Bit offset of the addressed lane
    logic [`DATA_WIDTH-1:0] storeData;
    logic [`DATA_WIDTH-1:0] laneData;

    assign access    = memRead | memWrite;
    assign laneShift = {aluAddress[1:0], 3'b000};
    assign storeData = memSource ? fpuData : regData; // FPU or register file

    always_comb begin
        goodOp     = 1'b1;
        misaligned = 1'b0;
        laneMask   = 4'b0001;
        case (memOp)
            memByte: laneMask = 4'b0001;
            memHalf: begin
                misaligned = aluAddress[0]; // Half-words need an even address
                laneMask   = 4'b0011;
            end
            memWord: begin
                misaligned = |aluAddress[1:0]; // Words need a multiple of four
                laneMask   = 4'b1111;
            end
            memByteU: goodOp = memRead & ~memWrite; // No unsigned stores
            memHalfU: begin
                goodOp     = memRead & ~memWrite;
                misaligned = aluAddress[0];
            end
            default: goodOp = 1'b0; // Zero result, no bus access
        endcase
    end

    // Request side of the bus
    assign bus.req   = access & goodOp & ~misaligned & ~pending;
    assign bus.dir   = memWrite ? busWrite : (memRead ? busRead : busIdle);
    assign bus.addr  = {aluAddress[`ADDR_WIDTH-1:2], 2'b00};
    assign bus.wdata = memWrite ? (storeData << laneShift) : '0;
    assign bus.strb  = memWrite ? (laneMask << aluAddress[1:0]) : 4'b0000;

    always_ff @(posedge clk) begin
        if (!rstN) begin
            pending <= 1'b0;
        end else if (bus.done) begin
            pending <= 1'b0; // Completion frees the handler
        end else if (bus.req) begin
            pending <= 1'b1;
        end
    end

    // Stall from the request cycle up to the completion cycle
    assign freeze   = access & goodOp & ~misaligned & ~bus.done;
    assign memError = access & ((goodOp & misaligned) | (bus.done & bus.err));

    assign laneData = bus.rdata >> laneShift; // Addressed lane down to bit 0

    always_comb begin
        dataToCpu = '0;
        if (memRead && !memWrite && bus.done && !bus.err) begin
            case (memOp)
                memByte:  dataToCpu = {{(`DATA_WIDTH-8){laneData[7]}}, laneData[7:0]};
                memHalf:  dataToCpu = {{(`DATA_WIDTH-16){laneData[15]}}, laneData[15:0]};
                memWord:  dataToCpu = laneData;
                memByteU: dataToCpu = {{(`DATA_WIDTH-8){1'b0}}, laneData[7:0]};
                memHalfU: dataToCpu = {{(`DATA_WIDTH-16){1'b0}}, laneData[15:0]};
                default:  dataToCpu = '0;
            endcase
        end
    end

endmodule

`default_nettype wire

/* rtl/memPkg.sv */
`default_nettype none

package memPkg;

    // Memory operation codes as issued by the control unit
    typedef enum logic [3:0] {
        memNone  = 4'd0, // No operation
        memByte  = 4'd1, // Signed byte
        memHalf  = 4'd2, // Signed half-word
        memWord  = 4'd3, // Full word
        memByteU = 4'd4, // Unsigned byte, loads only
        memHalfU = 4'd5  // Unsigned half-word, loads only
    } memOpE;

    // Direction of a request on the internal bus
    typedef enum logic [1:0] {
        busIdle  = 2'b00, // Nothing requested
        busWrite = 2'b01, // Store
        busRead  = 2'b10  // Load
    } busDirE;

    // APB master sequencing
    typedef enum logic [1:0] {
        apbIdle,  // Waiting for a request
        apbSetup, // PSEL high, PENABLE low
        apbAccess // PSEL and PENABLE high until PREADY
    } apbStateE;

endpackage

`default_nettype wire

/* rtl/memSubsystem.sv */
`include "mem_defs.svh"
`timescale 1ns/1ps
`default_nettype none

module memSubsystem import memPkg::*; (
    input  logic                   clk,
    input  logic                   rstN,
    input  memOpE                  memOp,
    input  logic                   memWrite,
    input  logic                   memRead,
    input  logic                   memSource,
    input  logic [`ADDR_WIDTH-1:0] aluAddress,
    input  logic [`DATA_WIDTH-1:0] fpuData,
    input  logic [`DATA_WIDTH-1:0] regData,
    output logic [`DATA_WIDTH-1:0] dataToCpu,
    output logic                   freeze,
    output logic                   memError
);
    // APB wires between master and memory
    logic                   psel;
    logic                   penable;
    logic                   pwrite;
    logic [`ADDR_WIDTH-1:0] paddr;
    logic [`DATA_WIDTH-1:0] pwdata;
    logic [3:0]             pstrb;
    logic [`DATA_WIDTH-1:0] prdata;
    logic                   pready;
    logic                   pslverr;

    memBus_if bus (.clk(clk)); // Handler to master link

    memHandler uHandler (
        .clk        (clk),
        .rstN       (rstN),
        .memOp      (memOp),
        .memWrite   (memWrite),
        .memRead    (memRead),
        .memSource  (memSource),
        .aluAddress (aluAddress),
        .fpuData    (fpuData),
        .regData    (regData),
        .dataToCpu  (dataToCpu),
        .freeze     (freeze),
        .memError   (memError),
        .bus        (bus.requester)
    );

    apbMaster uMaster (
        .clk     (clk),
        .rstN    (rstN),
        .bus     (bus.completer),
        .PSEL    (psel),
        .PENABLE (penable),
        .PWRITE  (pwrite),
        .PADDR   (paddr),
        .PWDATA  (pwdata),
        .PSTRB   (pstrb),
        .PRDATA  (prdata),
        .PREADY  (pready),
        .PSLVERR (pslverr)
    );

    dataMemory uMemory (
        .clk     (clk),
        .rstN    (rstN),
        .PSEL    (psel),
        .PENABLE (penable),
        .PWRITE  (pwrite),
        .PADDR   (paddr),
        .PWDATA  (pwdata),
        .PSTRB   (pstrb),
        .PRDATA  (prdata),
        .PREADY  (pready),
        .PSLVERR (pslverr)
    );

endmodule

`default_nettype wire

/* rtl/mem_defs.svh */
`ifndef MEM_DEFS_SVH
`define MEM_DEFS_SVH
`default_nettype none

// Datapath widths shared by the CPU side and the APB side
`define DATA_WIDTH 32 // Word width in bits
`define ADDR_WIDTH 32 // Byte address width

// Memory geometry
`define MEM_WORDS 256 // Depth in words, bytes beyond 4x this are out of range

// Slave timing
`define MEM_WAIT_STATES 2 // Extra access cycles before PREADY

`default_nettype wire
`endif

/* tests/memSubsystem_assert.sv */
`include "mem_defs.svh"
`timescale 1ns/1ps
`default_nettype none

module memSubsystem_assert (
    input logic                   clk,
    input logic                   rstN,
    input logic                   psel,
    input logic                   penable,
    input logic                   pwrite,
    input logic [`ADDR_WIDTH-1:0] paddr,
    input logic [`DATA_WIDTH-1:0] pwdata,
    input logic [3:0]             pstrb,
    input logic                   pready,
    input logic                   done,    // Completion pulse to the handler
    input logic                   pending, // Handler has an access outstanding
    input logic                   freeze
);
    // Access phase only straight out of a setup cycle
    enableAfterSetup: assert property (@(posedge clk) disable iff (!rstN)
        $rose(penable) |-> $past(psel) && !$past(penable))
        else $error("PENABLE rose without a preceding setup cycle");

    // Wait states hold the whole transfer
    stableWhileWait: assert property (@(posedge clk) disable iff (!rstN)
        psel && penable && !pready |=> psel && penable && $stable(paddr)
            && $stable(pwrite) && $stable(pwdata) && $stable(pstrb))
        else $error("APB outputs changed while PREADY was low");

    doneOnlyPending: assert property (@(posedge clk) disable iff (!rstN)
        done |-> pending)
        else $error("done pulsed with no access outstanding");

    // Bus idle and nothing outstanding on leaving reset
    idleAfterReset: assert property (@(posedge clk) $rose(rstN) |->
        !freeze && !psel && !penable && !done && !pending)
        else $error("freeze, PSEL, PENABLE, done or pending high on leaving reset");

endmodule

bind memSubsystem memSubsystem_assert uAssert (
    .clk(clk), .rstN(rstN), .psel(psel), .penable(penable), .pwrite(pwrite),
    .paddr(paddr), .pwdata(pwdata), .pstrb(pstrb), .pready(pready),
    .done(bus.done), .pending(uHandler.pending), .freeze(freeze)
);

`default_nettype wire

/* tests/memSubsystem_tb.sv */
`include "mem_defs.svh"
`timescale 1ns/1ps
`default_nettype none

module memSubsystem_tb import memPkg::*; ();
    localparam int MEM_BYTES = `MEM_WORDS * 4;
    localparam int TIMEOUT   = 50; // Cycles allowed for one access

    logic                   clk;
    logic                   rstN;
    memOpE                  memOp;
    logic                   memWrite;
    logic                   memRead;
    logic                   memSource;
    logic [`ADDR_WIDTH-1:0] aluAddress;
    logic [`DATA_WIDTH-1:0] fpuData;
    logic [`DATA_WIDTH-1:0] regData;
    logic [`DATA_WIDTH-1:0] dataToCpu;
    logic                   freeze;
    logic                   memError;

    logic [31:0]            lfsr = 32'h85f5;
    logic [7:0]             model [MEM_BYTES]; // Reference byte image
    logic [`DATA_WIDTH-1:0] gotData;           // Result of the last access
    logic                   gotErr;
    logic                   gotFroze;          // Freeze seen in the request cycle

    memSubsystem u_dut (.*);

    always #5 clk = ~clk;

    // Fibonacci LFSR with taps 32 22 2 1
    function automatic logic [31:0] randBits(input int n);
        logic [31:0] v;
        logic        fb;
        v = '0;
        for (int i = 0; i < n; i++) begin
            fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
            lfsr = {lfsr[30:0], fb};
            v    = {v[30:0], fb};
        end
        return v;
    endfunction

    function automatic int randAddr(input memOpE op);
        int a;
        a = int'(randBits(16) % MEM_BYTES);
        if (op == memWord) begin
            a = a & ~3;
        end else if (op == memHalf || op == memHalfU) begin
            a = a & ~1;
        end
        return a;
    endfunction

    // Little-endian lane extended with sign or zeros per code
    function automatic logic [`DATA_WIDTH-1:0] expectLoad(input memOpE op, input int a);
        case (op)
            memByte:  return {{24{model[a][7]}}, model[a]};
            memByteU: return {24'd0, model[a]};
            memHalf:  return {{16{model[a+1][7]}}, model[a+1], model[a]};
            memHalfU: return {16'd0, model[a+1], model[a]};
            memWord:  return {model[a+3], model[a+2], model[a+1], model[a]};
            default:  return '0;
        endcase
    endfunction

    task automatic modelStore(input memOpE op, input int a, input logic [31:0] d);
        int n;
        n = (op == memWord) ? 4 : ((op == memHalf) ? 2 : 1);
        for (int i = 0; i < n; i++) begin
            model[a+i] = d[8*i +: 8];
        end
    endtask

    task automatic abortRun(input string why);
        $display("%s", why);
        $display("tests failed");
        $fatal(1);
    endtask

    task automatic checkData(input logic [`DATA_WIDTH-1:0] got, exp, input string what);
        if (got !== exp) begin
            abortRun($sformatf("MISMATCH at %0t: %s data %h, expected %h",
                               $time, what, got, exp));
        end
    endtask

    task automatic checkError(input logic got, exp, input string what);
        if (got !== exp) begin
            abortRun($sformatf("MISMATCH at %0t: %s error %b, expected %b",
                               $time, what, got, exp));
        end
    endtask

    task automatic checkOp(input memOpE op, input logic got, exp, input string what);
        if (got !== exp) begin
            abortRun($sformatf("MISMATCH at %0t: %s code %0d freeze %b, expected %b",
                               $time, what, op, got, exp));
        end
    endtask

    // Present one request and release it once freeze drops
    task automatic runAccess(input memOpE op, input logic wr, input logic src,
                             input logic [`ADDR_WIDTH-1:0] a, input logic [`DATA_WIDTH-1:0] d);
        int waited;
        @(posedge clk);
        memOp      <= op;
        memWrite   <= wr;
        memRead    <= ~wr;
        memSource  <= src;
        aluAddress <= a;
        regData    <= src ? ~d : d; // Unused source gets a decoy
        fpuData    <= src ? d : ~d;
        @(negedge clk);
        gotFroze = freeze;
        waited   = 0;
        while (freeze) begin
            if (waited == TIMEOUT) begin
                abortRun("Timeout: freeze stayed high and the access never completed");
            end
            waited++;
            @(negedge clk);
        end
        gotData = dataToCpu;
        gotErr  = memError;
        @(posedge clk);
        memWrite <= 1'b0;
        memRead  <= 1'b0;
    endtask

    task automatic checkIdle(input int cycles);
        repeat (cycles) begin
            @(negedge clk);
            checkOp(memNone, freeze, 1'b0, "idle");
            checkError(memError, 1'b0, "idle");
            checkData(dataToCpu, '0, "idle");
        end
    endtask

    initial begin
        int                     a;
        logic [`DATA_WIDTH-1:0] d;
        memOpE                  op;
        clk        = 1'b0;
        rstN       = 1'b0;
        memOp      = memNone;
        memWrite   = 1'b0;
        memRead    = 1'b0;
        memSource  = 1'b0;
        aluAddress = '0;
        fpuData    = '0;
        regData    = '0;
        for (int i = 0; i < MEM_BYTES; i++) begin
            model[i] = 8'h00; // Memory starts cleared
        end
        repeat (16) @(posedge clk);
        rstN <= 1'b1;
        checkIdle(3);

        for (int src = 0; src < 2; src++) begin // Register file first and FPU second
            a = randAddr(memWord);
            d = randBits(32);
            runAccess(memWord, 1'b1, src[0], a, d);
            modelStore(memWord, a, d);
            checkError(gotErr, 1'b0, "word store");
            runAccess(memWord, 1'b0, 1'b0, a, '0);
            checkData(gotData, d, "word round trip");
        end

        repeat (300) begin // Random mix of aligned stores and loads
            if (randBits(1) != 0) begin
                op = memOpE'(4'(randBits(2) % 3 + 1));
                a  = randAddr(op);
                d  = randBits(32);
                runAccess(op, 1'b1, randBits(1) != 0, a, d);
                modelStore(op, a, d);
                checkData(gotData, '0, "store"); // Stores return nothing to the CPU
            end else begin
                op = memOpE'(4'(randBits(3) % 5 + 1));
                a  = randAddr(op);
                runAccess(op, 1'b0, 1'b0, a, '0);
                checkData(gotData, expectLoad(op, a), "load");
            end
            checkOp(op, gotFroze, 1'b1, "aligned access");
            checkError(gotErr, 1'b0, "aligned access");
        end

        a = randAddr(memWord) + 1 + int'(randBits(1)); // Word at offset 1 or 2
        runAccess(memWord, 1'b1, 1'b0, a, randBits(32));
        checkOp(memWord, gotFroze, 1'b0, "misaligned word store");
        checkError(gotErr, 1'b1, "misaligned word store");
        runAccess(memWord, 1'b0, 1'b0, a & ~3, '0);
        checkData(gotData, expectLoad(memWord, a & ~3), "word after misaligned store");
        a = randAddr(memHalf) | 1;
        runAccess(memHalf, 1'b1, 1'b0, a, randBits(32));
        checkError(gotErr, 1'b1, "misaligned half store");
        runAccess(memHalfU, 1'b0, 1'b0, a, '0);
        checkError(gotErr, 1'b1, "misaligned half load");
        checkData(gotData, '0, "misaligned half load");
        runAccess(memWord, 1'b0, 1'b0, a & ~3, '0);
        checkData(gotData, expectLoad(memWord, a & ~3), "word after misaligned half");

        a = randAddr(memWord);
        runAccess(memWord, 1'b0, 1'b0, MEM_BYTES + a, '0); // Beyond the array
        checkError(gotErr, 1'b1, "out-of-range load");
        checkData(gotData, '0, "out-of-range load");
        runAccess(memWord, 1'b1, 1'b0, MEM_BYTES + a, randBits(32));
        checkError(gotErr, 1'b1, "out-of-range store");
        runAccess(memWord, 1'b0, 1'b0, a, '0); // No aliasing into the array
        checkData(gotData, expectLoad(memWord, a), "word after out-of-range store");

        op = memOpE'(4'd6);
        runAccess(op, 1'b0, 1'b0, randAddr(memWord), '0);
        checkOp(op, gotFroze, 1'b0, "invalid code");
        checkError(gotErr, 1'b0, "invalid code");
        checkData(gotData, '0, "invalid code");
        runAccess(memByteU, 1'b1, 1'b0, randAddr(memByteU), randBits(32)); // No unsigned stores
        checkOp(memByteU, gotFroze, 1'b0, "unsigned store");

        checkIdle(4);
        $display("all tests passed");
        $finish;
    end

endmodule

`default_nettype wire
